// ==== hw/mob_params.svh ====
// Knight mobility widths and counts

`ifndef MOB_PARAMS_SVH
`define MOB_PARAMS_SVH

// Signed score width
`define EVAL_WIDTH 16

// Ranks per board, also files per rank
`define NUM_RANKS 8

// Bits per square code
`define PIECE_BITS 4

// Register stages in the score tree
`define TREE_STAGES 2

`endif

// ==== hw/chess_pkg.sv ====
// Board and piece encoding

`include "mob_params.svh"

package chess_pkg;

   // Colour in bit 3, piece kind in bits 2:0
   typedef logic [`PIECE_BITS-1:0] piece_t;

   localparam int COLOR_BIT = `PIECE_BITS - 1;  // Set for black

   typedef enum logic [2:0]
   {
      PIECE_NONE   = 3'd0,
      PIECE_PAWN   = 3'd1,
      PIECE_KNIGHT = 3'd2,
      PIECE_BISHOP = 3'd3,
      PIECE_ROOK   = 3'd4,
      PIECE_QUEEN  = 3'd5,
      PIECE_KING   = 3'd6
   } kind_t;

   localparam int NUM_SQUARES = `NUM_RANKS * `NUM_RANKS;

   // Index is rank * 8 + file, a1 = 0, h8 = 63
   typedef piece_t [NUM_SQUARES-1:0] board_t;

endpackage

// ==== hw/eval_pkg.sv ====
// Mobility score types and weights

`include "mob_params.svh"

package eval_pkg;

   typedef logic signed [`EVAL_WIDTH-1:0] score_t;

   localparam int KNIGHT_MOVES = 8;  // Most squares a knight reaches

   // Move count 0 to 8
   typedef logic [3:0] count_t;

   // Middle game weight per move count
   localparam score_t KNIGHT_MG [KNIGHT_MOVES+1] = '{
      -16'sd62, -16'sd53, -16'sd12, -16'sd4,
      16'sd3, 16'sd13, 16'sd22, 16'sd28,
      16'sd33
   };

   // End game weight per move count
   localparam score_t KNIGHT_EG [KNIGHT_MOVES+1] = '{
      -16'sd81, -16'sd56, -16'sd31, -16'sd16,
      16'sd5, 16'sd11, 16'sd17, 16'sd20,
      16'sd25
   };

   // Knight step offsets, rank then file
   localparam int STEP_RANK [KNIGHT_MOVES] = '{1, 2, 2, 1, -1, -2, -2, -1};
   localparam int STEP_FILE [KNIGHT_MOVES] = '{2, 1, -1, -2, -2, -1, 1, 2};

endpackage

// ==== hw/rank_if.sv ====
// Rank lane interface

`timescale 1ns/1ps

interface rank_if;

   chess_pkg::board_t board;  // Latched board, same for all lanes
   logic              board_valid;

   eval_pkg::score_t  mg;
   eval_pkg::score_t  eg;
   logic              score_valid;

   modport feeder
   (
      output board,
      output board_valid
   );

   modport lane
   (
      input  board,
      input  board_valid,
      output mg,
      output eg,
      output score_valid
   );

   modport drain (input mg, input eg, input score_valid);

endinterface

// ==== hw/board_latch.sv ====
// Input board register

`timescale 1ns/1ps

`include "mob_params.svh"

module board_latch
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               board_valid,
   input  chess_pkg::board_t  board,
   rank_if.feeder             ranks [`NUM_RANKS]
);

   chess_pkg::board_t board_q;
   logic              valid_q;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         valid_q <= 1'b0;
      else
         valid_q <= board_valid;
   end

   // Hold last accepted board
   always_ff @(posedge clk)
   begin
      if (board_valid)
         board_q <= board;
   end

   for (genvar r = 0; r < `NUM_RANKS; r++)
   begin : fan_out
      assign ranks[r].board       = board_q;
      assign ranks[r].board_valid = valid_q;
   end

endmodule

// ==== hw/knight_rank_eval.sv ====
// Knight mobility for one rank

`timescale 1ns/1ps

`include "mob_params.svh"

module knight_rank_eval
#(
   parameter int RANK = 0
)
(
   input  logic  clk,
   input  logic  arst_n,
   rank_if.lane  lane
);

   eval_pkg::score_t mg_next;
   eval_pkg::score_t eg_next;
   eval_pkg::score_t mg_q;
   eval_pkg::score_t eg_q;
   logic             valid_q;

   always_comb
   begin
      chess_pkg::piece_t me;
      chess_pkg::piece_t tgt;
      eval_pkg::count_t  cnt;
      int                r;
      int                c;

      mg_next = '0;
      eg_next = '0;
      for (int f = 0; f < `NUM_RANKS; f++)
      begin
         me  = lane.board[RANK * `NUM_RANKS + f];
         cnt = '0;
         for (int k = 0; k < eval_pkg::KNIGHT_MOVES; k++)
         begin
            r   = RANK + eval_pkg::STEP_RANK[k];
            c   = f + eval_pkg::STEP_FILE[k];
            tgt = '0;
            if (r >= 0 && r < `NUM_RANKS && c >= 0 && c < `NUM_RANKS)
            begin
               tgt = lane.board[r * `NUM_RANKS + c];
               // Empty or enemy square
               if (tgt[2:0] == chess_pkg::PIECE_NONE ||
                   tgt[chess_pkg::COLOR_BIT] != me[chess_pkg::COLOR_BIT])
                  cnt = cnt + 4'd1;
            end
         end

         if (me[2:0] == chess_pkg::PIECE_KNIGHT)
         begin
            if (me[chess_pkg::COLOR_BIT])  // Black counts against
            begin
               mg_next = mg_next - eval_pkg::KNIGHT_MG[cnt];
               eg_next = eg_next - eval_pkg::KNIGHT_EG[cnt];
            end
            else
            begin
               mg_next = mg_next + eval_pkg::KNIGHT_MG[cnt];
               eg_next = eg_next + eval_pkg::KNIGHT_EG[cnt];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         valid_q <= 1'b0;
      else
         valid_q <= lane.board_valid;
   end

   always_ff @(posedge clk)
   begin
      if (lane.board_valid)
      begin
         mg_q <= mg_next;
         eg_q <= eg_next;
      end
   end

   assign lane.mg          = mg_q;
   assign lane.eg          = eg_q;
   assign lane.score_valid = valid_q;

endmodule

// ==== hw/mob_score_tree.sv ====
// Rank score adder tree

`timescale 1ns/1ps

`include "mob_params.svh"

module mob_score_tree
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              clear_eval,
   rank_if.drain             lanes [`NUM_RANKS],
   output eval_pkg::score_t  eval_mg,
   output eval_pkg::score_t  eval_eg,
   output logic              eval_valid
);

   localparam int PAIRS = `NUM_RANKS >> (`TREE_STAGES - 1);

   eval_pkg::score_t lane_mg [`NUM_RANKS];
   eval_pkg::score_t lane_eg [`NUM_RANKS];
   eval_pkg::score_t pair_mg [PAIRS];
   eval_pkg::score_t pair_eg [PAIRS];
   eval_pkg::score_t total_mg;
   eval_pkg::score_t total_eg;
   logic             pair_valid;

   for (genvar i = 0; i < `NUM_RANKS; i++)
   begin : lane_tap
      assign lane_mg[i] = lanes[i].mg;
      assign lane_eg[i] = lanes[i].eg;
   end

   // Stage one
   always_ff @(posedge clk)
   begin
      if (lanes[0].score_valid)  // All lanes share one valid
      begin
         for (int p = 0; p < PAIRS; p++)
         begin
            pair_mg[p] <= lane_mg[2 * p] + lane_mg[2 * p + 1];
            pair_eg[p] <= lane_eg[2 * p] + lane_eg[2 * p + 1];
         end
      end
   end

   always_comb
   begin
      total_mg = '0;
      total_eg = '0;
      for (int p = 0; p < PAIRS; p++)
      begin
         total_mg = total_mg + pair_mg[p];
         total_eg = total_eg + pair_eg[p];
      end
   end

   // Stage two
   always_ff @(posedge clk)
   begin
      if (pair_valid)
      begin
         eval_mg <= total_mg;
         eval_eg <= total_eg;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pair_valid <= 1'b0;
         eval_valid <= 1'b0;
      end
      else
      begin
         pair_valid <= lanes[0].score_valid;
         if (pair_valid)
            eval_valid <= 1'b1;  // New result beats clear
         else if (clear_eval)
            eval_valid <= 1'b0;
      end
   end

endmodule

// ==== hw/knight_mob_eval.sv ====
// Knight mobility evaluator top

`timescale 1ns/1ps

`include "mob_params.svh"

module knight_mob_eval
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               board_valid,
   input  chess_pkg::board_t  board,
   input  logic               clear_eval,
   output eval_pkg::score_t   eval_mg,
   output eval_pkg::score_t   eval_eg,
   output logic               eval_valid
);

   rank_if ranks [`NUM_RANKS] ();

   board_latch board_latch_i
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .board_valid (board_valid),
      .board       (board),
      .ranks       (ranks)
   );

   for (genvar r = 0; r < `NUM_RANKS; r++)
   begin : rank_lane
      knight_rank_eval #(.RANK(r)) knight_rank_eval_i
      (
         .clk    (clk),
         .arst_n (arst_n),
         .lane   (ranks[r])
      );
   end

   mob_score_tree mob_score_tree_i
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .clear_eval (clear_eval),
      .lanes      (ranks),
      .eval_mg    (eval_mg),
      .eval_eg    (eval_eg),
      .eval_valid (eval_valid)
   );

endmodule

// ==== tests/knight_mob_tests.svh ====
// Directed knight mobility tests

`ifndef KNIGHT_MOB_TESTS_SVH
`define KNIGHT_MOB_TESTS_SVH

task automatic reset_and_empty();
   check_flag("valid after reset", eval_valid, 1'b0);
   run_board('0, 16'sd0, 16'sd0, "empty board");
endtask

task automatic lone_knights();
   chess_pkg::board_t b;

   b = '0;
   b[square_index(0, 0)] = W_KNIGHT;  // a1, 2 moves
   run_board(b, eval_pkg::KNIGHT_MG[2], eval_pkg::KNIGHT_EG[2], "white a1");
   b = '0;
   b[square_index(3, 3)] = W_KNIGHT;  // d4, 8 moves
   run_board(b, eval_pkg::KNIGHT_MG[8], eval_pkg::KNIGHT_EG[8], "white d4");
   b[square_index(3, 3)] = B_KNIGHT;
   run_board(b, -eval_pkg::KNIGHT_MG[8], -eval_pkg::KNIGHT_EG[8], "black d4");
endtask

task automatic blocked_knight();
   chess_pkg::board_t b;

   b = '0;
   b[square_index(0, 0)] = W_KNIGHT;
   b[square_index(2, 1)] = W_PAWN;  // b3
   b[square_index(1, 2)] = W_PAWN;  // c2
   run_board(b, eval_pkg::KNIGHT_MG[0], eval_pkg::KNIGHT_EG[0], "own pawns");
   b[square_index(2, 1)] = B_PAWN;
   b[square_index(1, 2)] = B_PAWN;
   run_board(b, eval_pkg::KNIGHT_MG[2], eval_pkg::KNIGHT_EG[2], "enemy pawns");
endtask

task automatic paired_knights();
   chess_pkg::board_t b;

   b = '0;
   b[square_index(0, 1)] = W_KNIGHT;  // Mirrored across the board
   b[square_index(0, 6)] = W_KNIGHT;
   b[square_index(7, 1)] = B_KNIGHT;
   b[square_index(7, 6)] = B_KNIGHT;
   run_board(b, 16'sd0, 16'sd0, "symmetric");
   b = '0;
   b[square_index(0, 0)] = W_KNIGHT;
   b[square_index(3, 3)] = W_KNIGHT;
   run_board(b, eval_pkg::KNIGHT_MG[2] + eval_pkg::KNIGHT_MG[8],
             eval_pkg::KNIGHT_EG[2] + eval_pkg::KNIGHT_EG[8], "two white");
endtask

task automatic stream_random();
   chess_pkg::board_t b;
   eval_pkg::score_t  mg;
   eval_pkg::score_t  eg;
   eval_pkg::score_t  mg_q [$];
   eval_pkg::score_t  eg_q [$];
   int                due_q [$];

   for (int n = 0; n < 200 || due_q.size() > 0; n++)
   begin
      board_valid = 1'b0;
      if (n < 200)
      begin
         random_board(b);
         model_eval(b, mg, eg);
         board       = b;
         board_valid = 1'b1;
         mg_q.push_back(mg);
         eg_q.push_back(eg);
         due_q.push_back(cycles + 4);  // Sampled next edge, out of the fourth register
      end
      step_cycle();
      if (due_q.size() > 0 && due_q[0] == cycles)
      begin
         check_flag("stream valid", eval_valid, 1'b1);
         check_score("stream mg", eval_mg, mg_q.pop_front());
         check_score("stream eg", eval_eg, eg_q.pop_front());
         void'(due_q.pop_front());
      end
   end
   board_valid = 1'b0;
endtask

task automatic clear_behavior();
   chess_pkg::board_t b;

   b = '0;
   b[square_index(3, 3)] = W_KNIGHT;
   run_board(b, eval_pkg::KNIGHT_MG[8], eval_pkg::KNIGHT_EG[8], "before clear");
   clear_eval = 1'b1;
   step_cycle();
   clear_eval = 1'b0;
   check_flag("valid after clear", eval_valid, 1'b0);
   repeat (3)
   begin
      step_cycle();
      check_flag("valid while idle", eval_valid, 1'b0);
   end

   // Clear lands on the same edge as the result
   b = '0;
   b[square_index(0, 0)] = W_KNIGHT;
   board       = b;
   board_valid = 1'b1;
   step_cycle();
   board_valid = 1'b0;
   repeat (2) step_cycle();
   clear_eval = 1'b1;
   step_cycle();
   clear_eval = 1'b0;
   check_flag("valid beats clear", eval_valid, 1'b1);
   check_score("late clear mg", eval_mg, eval_pkg::KNIGHT_MG[2]);
   check_score("late clear eg", eval_eg, eval_pkg::KNIGHT_EG[2]);
   step_cycle();
   check_flag("valid holds", eval_valid, 1'b1);
endtask

`endif

// ==== tests/knight_mob_eval_tb.sv ====
// Knight mobility evaluator testbench

`timescale 1ns/1ps

`include "mob_params.svh"

module knight_mob_eval_tb;

   localparam int TIMEOUT_CYCLES = 4000;  // About 250 boards at up to 10 cycles plus margin

   localparam chess_pkg::piece_t W_KNIGHT = 4'h2;
   localparam chess_pkg::piece_t B_KNIGHT = 4'hA;
   localparam chess_pkg::piece_t W_PAWN   = 4'h1;
   localparam chess_pkg::piece_t B_PAWN   = 4'h9;

   logic              clk;
   logic              arst_n;
   logic              board_valid;
   chess_pkg::board_t board;
   logic              clear_eval;
   eval_pkg::score_t  eval_mg;
   eval_pkg::score_t  eval_eg;
   logic              eval_valid;

   int                cycles;
   int                score_errors;
   int                flag_errors;
   logic [31:0]       rng_state;

   knight_mob_eval knight_mob_eval_i
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .board_valid (board_valid),
      .board       (board),
      .clear_eval  (clear_eval),
      .eval_mg     (eval_mg),
      .eval_eg     (eval_eg),
      .eval_valid  (eval_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Run stopped: tests still busy after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic int square_index(input int rank, input int file);
      return rank * `NUM_RANKS + file;
   endfunction

   // Mobility rule applied square by square
   function automatic void model_eval(input chess_pkg::board_t b,
                                      output eval_pkg::score_t mg,
                                      output eval_pkg::score_t eg);
      chess_pkg::piece_t p;
      chess_pkg::piece_t t;
      int                cnt;
      int                tr;
      int                tf;

      mg = '0;
      eg = '0;
      for (int sq = 0; sq < `NUM_RANKS * `NUM_RANKS; sq++)
      begin
         p = b[sq];
         if (p[2:0] == chess_pkg::PIECE_KNIGHT)
         begin
            cnt = 0;
            for (int dr = -2; dr <= 2; dr++)
               for (int df = -2; df <= 2; df++)
               begin
                  tr = sq / `NUM_RANKS + dr;
                  tf = sq % `NUM_RANKS + df;
                  if ((dr * df == 2 || dr * df == -2) && tr >= 0 && tr < `NUM_RANKS &&
                      tf >= 0 && tf < `NUM_RANKS)
                  begin
                     t = b[square_index(tr, tf)];
                     if (t == '0 || t[3] != p[3])
                        cnt++;
                  end
               end
            if (p[3])  // Black
            begin
               mg = mg - eval_pkg::KNIGHT_MG[cnt];
               eg = eg - eval_pkg::KNIGHT_EG[cnt];
            end
            else
            begin
               mg = mg + eval_pkg::KNIGHT_MG[cnt];
               eg = eg + eval_pkg::KNIGHT_EG[cnt];
            end
         end
      end
   endfunction

   task automatic check_score(input string what, input eval_pkg::score_t got,
                              input eval_pkg::score_t exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp);
         score_errors++;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
         flag_errors++;
      end
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #1;
   endtask

   // Clear, present one board, check the 4 cycle latency and the scores
   task automatic run_board(input chess_pkg::board_t b, input eval_pkg::score_t exp_mg,
                            input eval_pkg::score_t exp_eg, input string name);
      clear_eval = 1'b1;
      step_cycle();
      clear_eval  = 1'b0;
      board       = b;
      board_valid = 1'b1;
      for (int k = 1; k <= 3; k++)
      begin
         step_cycle();
         board_valid = 1'b0;
         check_flag({name, " early valid"}, eval_valid, 1'b0);
      end
      step_cycle();
      check_flag({name, " valid"}, eval_valid, 1'b1);
      check_score({name, " mg"}, eval_mg, exp_mg);
      check_score({name, " eg"}, eval_eg, exp_eg);
   endtask

   task automatic random_board(output chess_pkg::board_t b);
      logic [2:0] kind;

      for (int sq = 0; sq < `NUM_RANKS * `NUM_RANKS; sq++)
      begin
         rng_state = xorshift(rng_state);
         kind = (rng_state[2:0] == 3'd7) ? 3'd2 : rng_state[2:0];  // Extra knights
         if (rng_state[6:4] < 3'd3 || kind == 3'd0)
            b[sq] = '0;
         else
            b[sq] = {rng_state[3], kind};
      end
   endtask

   `include "knight_mob_tests.svh"

   initial
   begin
      arst_n       = 1'b0;
      board_valid  = 1'b0;
      board        = '0;
      clear_eval   = 1'b0;
      score_errors = 0;
      flag_errors  = 0;
      rng_state    = 32'h7aaf_6c62;
      repeat (2) @(posedge clk);
      #1 arst_n = 1'b1;

      reset_and_empty();
      lone_knights();
      blocked_knight();
      paired_knights();
      stream_random();
      clear_behavior();

      $display("Errors: %0d score, %0d flag", score_errors, flag_errors);
      if (score_errors + flag_errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== knight_mob_eval.f ====
+incdir+hw
+incdir+tests
hw/chess_pkg.sv
hw/eval_pkg.sv
hw/rank_if.sv
hw/board_latch.sv
hw/knight_rank_eval.sv
hw/mob_score_tree.sv
hw/knight_mob_eval.sv
tests/knight_mob_eval_tb.sv
